// File: flist.f
cpu_pkg.sv
reg_file.sv
instr_decode.sv
alu.sv
data_mem.sv
exe_wb.sv
cpu_core.sv
cpu_checker.sv
tb_cpu_core.sv

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module tb_cpu_core &&
./obj_dir/Vtb_cpu_core | tee /dev/stderr | grep -q "Finished with no errors" ||
exit 1

// File: tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core;
	import cpu_pkg::*;

	localparam int mem_aw     = 5;
	localparam int n_directed = 28;
	localparam int n_rand     = 200;
	localparam int max_cycles = (n_directed + n_rand) * 10 + 200;

	logic                clk = 1'b0;
	logic                pclk;
	logic                in_req;
	instr_word_t         in_instr;
	logic                in_ack;
	logic                write_reg_ctrl;
	logic [reg_aw-1:0]   write_reg_addr;
	logic [data_w-1:0]   write_reg_data;

	logic [data_w-1:0]   model_regs [num_regs];
	logic [data_w-1:0]   model_mem [2**mem_aw];
	logic [18:0]         exp_q [$];  // {addr, data} in program order
	logic [18:0]         exp_cur;
	string               cur_test;
	int                  errors;
	int                  checks;
	int                  test_errors;
	int                  cycles;
	integer              seed;
	logic [31:0]         rnd;
	int                  sel;
	instr_word_t         w;

	cpu_core #(.mem_aw(mem_aw)) cpu_core_inst (
		.clk, .pclk, .in_req, .in_instr, .in_ack,
		.write_reg_ctrl, .write_reg_addr, .write_reg_data
	);

	bind cpu_core cpu_checker cpu_checker_inst (
		.clk(clk), .pclk(pclk), .in_req(in_req), .in_ack(in_ack),
		.write_reg_ctrl(write_reg_ctrl), .write_reg_addr(write_reg_addr),
		.unlock_reg(unlock_reg), .unlock_reg_addr(unlock_reg_addr)
	);

	initial begin
		forever #4 clk = ~clk;
	end

	function automatic instr_word_t ri_word(input logic [4:0] op, input logic [2:0] rx,
		input logic [7:0] imm8);
		return {op, rx, imm8};
	endfunction

	function automatic instr_word_t rrr_word(input logic [4:0] op, input logic [2:0] rx,
		input logic [2:0] ry, input logic [2:0] rz, input logic [1:0] funct);
		return {op, rx, ry, rz, funct};
	endfunction

	function automatic instr_word_t mem_word(input logic [4:0] op, input logic [2:0] base,
		input logic [2:0] ry, input logic [4:0] imm5);
		return {op, base, ry, imm5};
	endfunction

	// Architectural model, updates state and reports the expected write
	function automatic bit ref_exec(input instr_word_t iw, output logic [2:0] addr,
		output logic [15:0] data);
		logic [15:0]       ea;
		logic [3:0]        sh;
		logic [mem_aw-1:0] ma;
		bit                wr;
		wr   = 1'b0;
		addr = iw.rrr.rx;
		data = '0;
		ea   = model_regs[iw.ri.rx] + {{11{iw.ri.imm8[4]}}, iw.ri.imm8[4:0]};
		ma   = ea[mem_aw-1:0];
		sh   = (iw.rrr.rz == 3'd0) ? 4'd8 : {1'b0, iw.rrr.rz};
		case (iw.ri.op)
			op_li: begin
				wr   = 1'b1;
				data = {8'h00, iw.ri.imm8};
			end
			op_addiu: begin
				wr   = 1'b1;
				data = model_regs[iw.ri.rx] + {{8{iw.ri.imm8[7]}}, iw.ri.imm8};
			end
			op_sll: begin
				wr   = (iw.rrr.funct == 2'b00);
				data = model_regs[iw.rrr.ry] << sh;
			end
			op_addu: begin
				wr   = (iw.rrr.funct == 2'b01);
				addr = iw.rrr.rz;
				data = model_regs[iw.rrr.rx] + model_regs[iw.rrr.ry];
			end
			op_move: begin
				wr   = (iw.ri.imm8[4:0] == 5'b00000);
				data = model_regs[iw.rrr.ry];
			end
			op_lw: begin
				wr   = 1'b1;
				addr = iw.rrr.ry;
				data = model_mem[ma];
			end
			op_sw: model_mem[ma] = model_regs[iw.rrr.ry];
			default: ;  // NOP and unknown opcodes
		endcase
		if (wr)
			model_regs[addr] = data;
		return wr;
	endfunction

	// One draw from the supported set, NOP and two unused opcodes
	function automatic instr_word_t random_instr(input int pick, input logic [15:0] b);
		case (pick)
			0: return {op_li, b[10:0]};
			1: return {op_addiu, b[10:0]};
			2: return {op_sll, b[10:2], 2'b00};
			3: return {op_addu, b[10:2], 2'b01};
			4: return {op_move, b[10:5], 5'b00000};
			5: return {op_lw, b[10:0]};
			6: return {op_sw, b[10:0]};
			7: return nop_word;
			8: return {5'b00000, b[10:0]};
			default: return {5'b11111, b[10:0]};
		endcase
	endfunction

	task automatic check_val(input string what, input logic [15:0] exp,
		input logic [15:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Fail %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
		end
	endtask

	// Full four-phase transfer, model runs when the ack is seen
	task automatic send_instr(input instr_word_t iw);
		logic [2:0]  a;
		logic [15:0] d;
		bit          wr;
		@(negedge clk);
		in_instr = iw;
		in_req   = 1'b1;
		@(negedge clk);
		while (!in_ack) @(negedge clk);
		wr = ref_exec(iw, a, d);
		if (wr)
			exp_q.push_back({a, d});
		in_req = 1'b0;
		@(negedge clk);
		while (in_ack) @(negedge clk);
	endtask

	task automatic finish_test();
		while (exp_q.size() != 0) @(negedge clk);
		repeat (3) @(negedge clk);  // Catch stray writes
		$display("Test %s done, %0d errors", cur_test, errors - test_errors);
		test_errors = errors;
	endtask

	// Compare every write pulse against the oldest expected write
	always @(negedge clk) begin
		if (!pclk && write_reg_ctrl) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("Error in %s: register write to r%0d with no write expected",
					cur_test, write_reg_addr);
			end else begin
				exp_cur = exp_q.pop_front();
				check_val("address", 16'(exp_cur[18:16]), 16'(write_reg_addr));
				check_val("data", exp_cur[15:0], write_reg_data);
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Error: run timed out after %0d cycles", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		pclk        = 1'b1;
		in_req      = 1'b0;
		in_instr    = nop_word;
		errors      = 0;
		checks      = 0;
		test_errors = 0;
		cycles      = 0;
		seed        = 96;
		for (int i = 0; i < num_regs; i++)
			model_regs[i] = '0;
		for (int i = 0; i < 2**mem_aw; i++)
			model_mem[i] = '0;

		cur_test = "reset";
		repeat (16) begin
			@(negedge clk);
			check_val("in_ack", 16'h0, 16'(in_ack));
			check_val("write_reg_ctrl", 16'h0, 16'(write_reg_ctrl));
		end
		pclk = 1'b0;
		repeat (3) begin
			@(negedge clk);
			check_val("in_ack", 16'h0, 16'(in_ack));
			check_val("write_reg_ctrl", 16'h0, 16'(write_reg_ctrl));
		end
		for (int i = 0; i < num_regs; i++)
			send_instr(ri_word(op_li, 3'(i), 8'(i * 41 + 7)));
		finish_test();

		cur_test = "arithmetic";
		send_instr(ri_word(op_addiu, 3'd1, 8'h05));
		send_instr(ri_word(op_addiu, 3'd2, 8'hfd));  // Minus three
		send_instr(rrr_word(op_addu, 3'd1, 3'd2, 3'd3, 2'b01));
		send_instr(rrr_word(op_move, 3'd4, 3'd3, 3'd0, 2'b00));
		send_instr(rrr_word(op_sll, 3'd5, 3'd2, 3'd3, 2'b00));
		send_instr(rrr_word(op_sll, 3'd6, 3'd7, 3'd0, 2'b00));  // Shift by 8
		finish_test();

		cur_test = "memory";
		send_instr(mem_word(op_sw, 3'd0, 3'd3, 5'h04));
		send_instr(mem_word(op_sw, 3'd1, 3'd5, 5'h1e));  // Offset of minus two
		send_instr(mem_word(op_sw, 3'd2, 3'd6, 5'h0f));
		send_instr(mem_word(op_lw, 3'd0, 3'd7, 5'h04));
		send_instr(mem_word(op_lw, 3'd1, 3'd4, 5'h1e));
		send_instr(mem_word(op_lw, 3'd2, 3'd5, 5'h0f));
		finish_test();

		cur_test = "dependency";
		send_instr(ri_word(op_addiu, 3'd1, 8'h01));
		send_instr(rrr_word(op_addu, 3'd1, 3'd1, 3'd2, 2'b01));
		send_instr(rrr_word(op_sll, 3'd3, 3'd2, 3'd1, 2'b00));
		send_instr(rrr_word(op_move, 3'd4, 3'd3, 3'd0, 2'b00));
		send_instr(ri_word(op_addiu, 3'd4, 8'hff));
		send_instr(ri_word(op_addiu, 3'd4, 8'h07));  // Second write to r4
		send_instr(mem_word(op_sw, 3'd0, 3'd4, 5'h08));
		send_instr(mem_word(op_lw, 3'd0, 3'd6, 5'h08));
		finish_test();

		cur_test = "random";
		repeat (n_rand) begin
			rnd = $random(seed);
			sel = int'(rnd[23:16]) % 10;
			w   = random_instr(sel, rnd[15:0]);
			send_instr(w);
		end
		finish_test();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker (
	input  logic                        clk,
	input  logic                        pclk,
	input  logic                        in_req,
	input  logic                        in_ack,
	input  logic                        write_reg_ctrl,
	input  logic [cpu_pkg::reg_aw-1:0]  write_reg_addr,
	input  logic                        unlock_reg,
	input  logic [cpu_pkg::reg_aw-1:0]  unlock_reg_addr
);

	// Ack answers only a live request
	ack_rise: assert property (@(posedge clk) disable iff (pclk)
		$rose(in_ack) |-> $past(in_req)) else $error("in_ack rose without in_req");

	ack_fall: assert property (@(posedge clk) disable iff (pclk)
		$fell(in_ack) |-> !$past(in_req)) else $error("in_ack fell while in_req high");

	// Unlock mirrors the register write
	unlock_match: assert property (@(posedge clk) disable iff (pclk)
		(unlock_reg == write_reg_ctrl) &&
		(!unlock_reg || unlock_reg_addr == write_reg_addr))
		else $error("unlock differs from register write");

	reset_quiet: assert property (@(posedge clk)
		pclk |-> !in_ack && !write_reg_ctrl) else $error("outputs active in reset");

endmodule

// File: cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
	parameter int mem_aw = 5
) (
	input  logic                        clk,
	input  logic                        pclk,
	input  logic                        in_req,
	input  cpu_pkg::instr_word_t        in_instr,
	output logic                        in_ack,
	output logic                        write_reg_ctrl,
	output logic [cpu_pkg::reg_aw-1:0]  write_reg_addr,
	output logic [cpu_pkg::data_w-1:0]  write_reg_data
);
	import cpu_pkg::*;

	// Decode and register file
	logic [reg_aw-1:0] rd_addr_a;
	logic [reg_aw-1:0] rd_addr_b;
	logic [data_w-1:0] rd_data_a;
	logic [data_w-1:0] rd_data_b;
	logic              unlock_reg;
	logic [reg_aw-1:0] unlock_reg_addr;
	instr_word_t       dec_instr;
	logic [data_w-1:0] dec_a;
	logic [data_w-1:0] dec_b;

	// Execute to memory and writeback
	logic [mem_aw-1:0] mem_addr;
	logic [data_w-1:0] mem_wdata;
	logic              mem_we;
	logic [data_w-1:0] mem_read_value;
	logic [data_w-1:0] alu_res;
	logic [reg_aw-1:0] reg_addr;
	instr_word_t       opn;

	instr_decode instr_decode_inst (
		.clk, .pclk, .in_req, .in_instr, .in_ack,
		.rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
		.unlock_reg, .unlock_reg_addr,
		.dec_instr, .dec_a, .dec_b
	);

	alu #(.mem_aw(mem_aw)) alu_inst (
		.clk, .pclk, .dec_instr, .dec_a, .dec_b,
		.mem_addr, .mem_wdata, .mem_we,
		.alu_res, .reg_addr, .opn
	);

	data_mem #(.mem_aw(mem_aw)) data_mem_inst (
		.clk, .mem_addr, .mem_wdata, .mem_we, .mem_read_value
	);

	exe_wb exe_wb_inst (
		.clk, .pclk, .alu_res, .reg_addr, .opn, .mem_read_value,
		.write_reg_ctrl, .write_reg_addr, .write_reg_data,
		.unlock_reg, .unlock_reg_addr
	);

	reg_file reg_file_inst (
		.clk, .pclk, .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
		.write_reg_ctrl, .write_reg_addr, .write_reg_data
	);

endmodule

// File: exe_wb.sv
`timescale 1ns/1ps

module exe_wb (
	input  logic                        clk,
	input  logic                        pclk,
	input  logic [cpu_pkg::data_w-1:0]  alu_res,
	input  logic [cpu_pkg::reg_aw-1:0]  reg_addr,
	input  cpu_pkg::instr_word_t        opn,
	input  logic [cpu_pkg::data_w-1:0]  mem_read_value,
	output logic                        write_reg_ctrl,
	output logic [cpu_pkg::reg_aw-1:0]  write_reg_addr,
	output logic [cpu_pkg::data_w-1:0]  write_reg_data,
	output logic                        unlock_reg,
	output logic [cpu_pkg::reg_aw-1:0]  unlock_reg_addr
);
	import cpu_pkg::*;

	logic              wr_en;
	logic [data_w-1:0] wr_data;

	always_comb begin
		wr_en   = 1'b0;
		wr_data = alu_res;
		case (opn.ri.op)
			op_li:    wr_en = 1'b1;
			op_addiu: wr_en = 1'b1;
			op_sll:   wr_en = (opn.rrr.funct == fn_sll);
			op_addu:  wr_en = (opn.rrr.funct == fn_addu);
			op_move:  wr_en = (opn.ri.imm8[4:0] == 5'b00000);
			op_lw: begin
				wr_en   = 1'b1;
				wr_data = mem_read_value;
			end
			op_sw, op_nop: wr_en = 1'b0; // Retire with no register write
			default: wr_en = 1'b0;
		endcase
	end

	// Write strobe and unlock pulse together
	always_ff @(posedge clk or posedge pclk) begin
		if (pclk) begin
			write_reg_ctrl <= 1'b0;
			unlock_reg     <= 1'b0;
		end else begin
			write_reg_ctrl <= wr_en;
			unlock_reg     <= wr_en;
		end
	end

	always_ff @(posedge clk) begin
		write_reg_addr  <= reg_addr;
		write_reg_data  <= wr_data;
		unlock_reg_addr <= reg_addr;
	end

endmodule

// File: data_mem.sv
`timescale 1ns/1ps

module data_mem #(
	parameter int mem_aw = 5
) (
	input  logic                        clk,
	input  logic [mem_aw-1:0]           mem_addr,
	input  logic [cpu_pkg::data_w-1:0]  mem_wdata,
	input  logic                        mem_we,
	output logic [cpu_pkg::data_w-1:0]  mem_read_value
);

	logic [cpu_pkg::data_w-1:0] mem [2**mem_aw];

	// Power-up contents are zero
	initial begin
		for (int i = 0; i < 2**mem_aw; i++)
			mem[i] = '0;
	end

	always_ff @(posedge clk) begin
		if (mem_we)
			mem[mem_addr] <= mem_wdata;
		mem_read_value <= mem[mem_addr]; // Old data on a same-cycle write
	end

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu #(
	parameter int mem_aw = 5
) (
	input  logic                        clk,
	input  logic                        pclk,
	input  cpu_pkg::instr_word_t        dec_instr,
	input  logic [cpu_pkg::data_w-1:0]  dec_a,
	input  logic [cpu_pkg::data_w-1:0]  dec_b,
	output logic [mem_aw-1:0]           mem_addr,
	output logic [cpu_pkg::data_w-1:0]  mem_wdata,
	output logic                        mem_we,
	output logic [cpu_pkg::data_w-1:0]  alu_res,
	output logic [cpu_pkg::reg_aw-1:0]  reg_addr,
	output cpu_pkg::instr_word_t        opn
);
	import cpu_pkg::*;

	logic [data_w-1:0] imm8_sx;
	logic [data_w-1:0] imm5_sx;
	logic [data_w-1:0] ea;
	logic [3:0]        shamt;
	logic [data_w-1:0] res;
	logic [reg_aw-1:0] dst;

	assign imm8_sx = {{(data_w-8){dec_instr.ri.imm8[7]}}, dec_instr.ri.imm8};
	assign imm5_sx = {{(data_w-5){dec_instr.ri.imm8[4]}}, dec_instr.ri.imm8[4:0]};
	assign ea      = dec_a + imm5_sx;
	assign shamt   = (dec_instr.rrr.rz == 3'd0) ? 4'd8 : {1'b0, dec_instr.rrr.rz};

	// Memory side, straight from the decode register
	assign mem_addr  = ea[mem_aw-1:0];
	assign mem_wdata = dec_b;
	assign mem_we    = (dec_instr.ri.op == op_sw);

	always_comb begin
		res = ea;
		dst = dec_instr.rrr.rx;
		case (dec_instr.ri.op)
			op_li:    res = {{(data_w-8){1'b0}}, dec_instr.ri.imm8};
			op_addiu: res = dec_a + imm8_sx;
			op_sll:   res = dec_b << shamt;
			op_addu: begin
				res = dec_a + dec_b;
				dst = dec_instr.rrr.rz;
			end
			op_move:  res = dec_b;
			op_lw:    dst = dec_instr.rrr.ry; // Data comes from memory
			default:  ;
		endcase
	end

	always_ff @(posedge clk or posedge pclk) begin
		if (pclk)
			opn <= nop_word;
		else
			opn <= dec_instr;
	end

	always_ff @(posedge clk) begin
		alu_res  <= res;
		reg_addr <= dst;
	end

endmodule

// File: instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
	input  logic                        clk,
	input  logic                        pclk,
	input  logic                        in_req,
	input  cpu_pkg::instr_word_t        in_instr,
	output logic                        in_ack,
	output logic [cpu_pkg::reg_aw-1:0]  rd_addr_a,
	output logic [cpu_pkg::reg_aw-1:0]  rd_addr_b,
	input  logic [cpu_pkg::data_w-1:0]  rd_data_a,
	input  logic [cpu_pkg::data_w-1:0]  rd_data_b,
	input  logic                        unlock_reg,
	input  logic [cpu_pkg::reg_aw-1:0]  unlock_reg_addr,
	output cpu_pkg::instr_word_t        dec_instr,
	output logic [cpu_pkg::data_w-1:0]  dec_a,
	output logic [cpu_pkg::data_w-1:0]  dec_b
);
	import cpu_pkg::*;

	logic [num_regs-1:0] lock;
	logic [num_regs-1:0] set_mask;
	logic [num_regs-1:0] clr_mask;
	logic                use_a;
	logic                use_b;
	logic                wr_en;
	logic [reg_aw-1:0]   dest;
	logic                hazard;
	logic                accept;

	// Operands always come from rx and ry
	assign rd_addr_a = in_instr.rrr.rx;
	assign rd_addr_b = in_instr.rrr.ry;

	// Which registers the waiting instruction touches
	always_comb begin
		use_a = 1'b0;
		use_b = 1'b0;
		wr_en = 1'b0;
		dest  = in_instr.rrr.rx;
		case (in_instr.ri.op)
			op_li: wr_en = 1'b1;
			op_addiu: begin
				use_a = 1'b1;
				wr_en = 1'b1;
			end
			op_sll: begin
				use_b = (in_instr.rrr.funct == fn_sll);
				wr_en = (in_instr.rrr.funct == fn_sll);
			end
			op_addu: begin
				use_a = (in_instr.rrr.funct == fn_addu);
				use_b = (in_instr.rrr.funct == fn_addu);
				wr_en = (in_instr.rrr.funct == fn_addu);
				dest  = in_instr.rrr.rz;
			end
			op_move: begin
				use_b = (in_instr.ri.imm8[4:0] == 5'b00000);
				wr_en = (in_instr.ri.imm8[4:0] == 5'b00000);
			end
			op_lw: begin
				use_a = 1'b1;
				wr_en = 1'b1;
				dest  = in_instr.rrr.ry;
			end
			op_sw: begin
				use_a = 1'b1;
				use_b = 1'b1;
			end
			default: ; // NOP and unknown touch nothing
		endcase
	end

	assign hazard = (use_a && lock[in_instr.rrr.rx]) ||
	                (use_b && lock[in_instr.rrr.ry]) ||
	                (wr_en && lock[dest]);
	assign accept = in_req && !in_ack && !hazard;

	always_comb begin
		set_mask = '0;
		clr_mask = '0;
		if (accept && wr_en)
			set_mask[dest] = 1'b1;
		if (unlock_reg)
			clr_mask[unlock_reg_addr] = 1'b1;
	end

	always_ff @(posedge clk or posedge pclk) begin
		if (pclk) begin
			in_ack    <= 1'b0;
			lock      <= '0;
			dec_instr <= nop_word;
		end else begin
			if (accept)
				in_ack <= 1'b1;
			else if (!in_req)
				in_ack <= 1'b0; // Phase four
			lock      <= (lock & ~clr_mask) | set_mask; // Set beats clear
			dec_instr <= accept ? in_instr : instr_word_t'(nop_word);
		end
	end

	// Operand values ride along with the instruction
	always_ff @(posedge clk) begin
		dec_a <= rd_data_a;
		dec_b <= rd_data_b;
	end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                        clk,
	input  logic                        pclk,
	input  logic [cpu_pkg::reg_aw-1:0]  rd_addr_a,
	input  logic [cpu_pkg::reg_aw-1:0]  rd_addr_b,
	output logic [cpu_pkg::data_w-1:0]  rd_data_a,
	output logic [cpu_pkg::data_w-1:0]  rd_data_b,
	input  logic                        write_reg_ctrl,
	input  logic [cpu_pkg::reg_aw-1:0]  write_reg_addr,
	input  logic [cpu_pkg::data_w-1:0]  write_reg_data
);
	import cpu_pkg::*;

	logic [data_w-1:0] regs [num_regs];

	// Reads see the value before this edge's write
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

	always_ff @(posedge clk or posedge pclk) begin
		if (pclk) begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= '0;
		end else if (write_reg_ctrl) begin
			regs[write_reg_addr] <= write_reg_data;
		end
	end

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

	localparam int data_w   = 16;
	localparam int reg_aw   = 3;
	localparam int num_regs = 8;

	// Major opcodes, bits 15:11
	localparam logic [4:0] op_li    = 5'b01101;
	localparam logic [4:0] op_addiu = 5'b01001;
	localparam logic [4:0] op_sll   = 5'b00110;
	localparam logic [4:0] op_addu  = 5'b11100;
	localparam logic [4:0] op_move  = 5'b01111;
	localparam logic [4:0] op_lw    = 5'b10011;
	localparam logic [4:0] op_sw    = 5'b11011;
	localparam logic [4:0] op_nop   = 5'b00001;

	// Function field for the rrr forms
	localparam logic [1:0] fn_sll  = 2'b00;
	localparam logic [1:0] fn_addu = 2'b01;

	// Bubble that fills empty stages
	localparam logic [15:0] nop_word = {op_nop, 11'b10000000000};

	typedef struct packed {
		logic [4:0] op;
		logic [2:0] rx;
		logic [2:0] ry;
		logic [2:0] rz;     // Also the SLL shift amount
		logic [1:0] funct;
	} rrr_word_t;

	typedef struct packed {
		logic [4:0] op;
		logic [2:0] rx;
		logic [7:0] imm8;   // LW and SW use the low five bits
	} ri_word_t;

	// Same 16 bits, two field layouts
	typedef union packed {
		rrr_word_t rrr;
		ri_word_t  ri;
	} instr_word_t;

endpackage
